// File: source/dsp_pkg.sv
package dsp_pkg;

	// Source and destination fields address 16 channels or 16 bank registers
	localparam int reg_addr_width = 4;
	localparam int n_channels = 1 << reg_addr_width;
	localparam int n_registers = 1 << reg_addr_width;
	localparam int shift_width = 4;

	typedef enum logic [4:0] {
		NOP = 5'd0,
		ADD = 5'd1,
		SUB = 5'd2,
		LSH = 5'd3,
		RSH = 5'd4,
		ARSH = 5'd5,
		ABS = 5'd6,
		MOV = 5'd7,
		CLAMP = 5'd8,
		MUL = 5'd9,
		MACZ = 5'd10,
		MAC = 5'd11,
		MOV_ACC = 5'd12
	} opcode_e;

	typedef struct packed {
		opcode_e op;
		logic saturate;
		logic [shift_width - 1:0] shift;
		logic [reg_addr_width - 1:0] src_a;
		logic src_a_reg;                    // Bank register when set, channel when clear
		logic [reg_addr_width - 1:0] src_b;
		logic src_b_reg;
		logic [reg_addr_width - 1:0] dest;  // Always a channel
	} instr_t;

	typedef enum logic [2:0] {
		IDLE,
		FETCH_INSTR,
		FETCH_OPERANDS,
		DISPATCH,
		WAIT_UNIT,
		WRITE_BACK,
		NEXT_BLOCK,
		FINISH
	} seq_state_e;

endpackage

// File: source/block_memory.sv
module block_memory import dsp_pkg::*; #(
	parameter int data_width = 16,
	parameter int n_blocks = 16
) (
	input logic clk,
	input logic reset,
	input logic instr_write,
	input logic [$clog2(n_blocks) - 1:0] instr_block,
	input instr_t instr_value,
	input logic reg_write,
	input logic [$clog2(n_blocks) - 1:0] reg_block,
	input logic [reg_addr_width - 1:0] reg_index,
	input logic signed [data_width - 1:0] reg_value,
	input logic [$clog2(n_blocks) - 1:0] block_index,
	input logic operand_fetch,
	input logic ch_write,
	input logic [reg_addr_width - 1:0] ch_addr,
	input logic signed [data_width - 1:0] ch_value,
	input logic sample_load,
	input logic signed [data_width - 1:0] sample_value,
	output instr_t instr,
	output logic signed [data_width - 1:0] operand_a,
	output logic signed [data_width - 1:0] operand_b,
	output logic [$clog2(n_blocks) - 1:0] last_block,
	output logic signed [data_width - 1:0] channel0
);
	instr_t program_mem [n_blocks];
	logic signed [data_width - 1:0] bank_mem [n_blocks * n_registers];
	logic signed [data_width - 1:0] channels [n_channels];

	assign channel0 = channels[0];

	always_ff @(posedge clk) begin
		if (instr_write)
			program_mem[instr_block] <= instr_value;
		if (reg_write)
			bank_mem[{reg_block, reg_index}] <= reg_value;

		instr <= program_mem[block_index];  // Held stable while the sequencer keeps the index

		// Operand sources follow the flags of the instruction already fetched
		if (operand_fetch) begin
			operand_a <= instr.src_a_reg ? bank_mem[{block_index, instr.src_a}]
				: channels[instr.src_a];
			operand_b <= instr.src_b_reg ? bank_mem[{block_index, instr.src_b}]
				: channels[instr.src_b];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			last_block <= '0;
			for (int i = 0; i < n_channels; i++)
				channels[i] <= '0;
		end else begin
			if (instr_write && instr_block > last_block)
				last_block <= instr_block;

			if (sample_load)
				channels[0] <= sample_value;  // The sequencer never writes back during a load
			else if (ch_write)
				channels[ch_addr] <= ch_value;
		end
	end

endmodule

// File: source/alu_unit.sv
module alu_unit import dsp_pkg::*; #(
	parameter int data_width = 16
) (
	input logic clk,
	input logic reset,
	input logic req,
	input opcode_e op,
	input logic signed [data_width - 1:0] a,
	input logic signed [data_width - 1:0] b,
	input logic saturate,
	input logic [shift_width - 1:0] shift,
	output logic ack,
	output logic signed [data_width - 1:0] result
);
	localparam logic signed [data_width - 1:0] max_w = {1'b0, {(data_width - 1){1'b1}}};
	localparam logic signed [data_width - 1:0] min_w = {1'b1, {(data_width - 1){1'b0}}};

	logic signed [data_width:0] sum_wide;
	logic signed [data_width - 1:0] sum_clipped;
	logic signed [data_width - 1:0] bound_max;
	logic signed [data_width - 1:0] bound_min;
	logic signed [data_width - 1:0] value;

	// One extra bit keeps the exact sum or difference
	assign sum_wide = (op == SUB) ? a - b : a + b;
	assign sum_clipped = (sum_wide > max_w) ? max_w
		: (sum_wide < min_w) ? min_w : sum_wide[data_width - 1:0];

	assign bound_max = max_w >>> shift;
	assign bound_min = min_w >>> shift;

	always_comb begin
		case (op)
			ADD, SUB:
				value = saturate ? sum_clipped : sum_wide[data_width - 1:0];
			LSH:
				value = {a[data_width - 2:0], 1'b0};
			RSH:
				value = {1'b0, a[data_width - 1:1]};
			ARSH:
				value = a >>> 1;
			ABS:
				value = a[data_width - 1] ? -a : a;  // Negating min wraps back to min
			MOV:
				value = a;
			CLAMP:
				value = (a > bound_max) ? bound_max : (a < bound_min) ? bound_min : a;
			default:
				value = '0;
		endcase
	end

	// Handshake phase
	always_ff @(posedge clk) begin
		if (reset)
			ack <= 1'b0;
		else if (req && !ack)
			ack <= 1'b1;
		else if (!req)
			ack <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (req && !ack)
			result <= value;  // Stays put until the next request
	end

endmodule

// File: source/mac_unit.sv
module mac_unit import dsp_pkg::*; #(
	parameter int data_width = 16
) (
	input logic clk,
	input logic reset,
	input logic req,
	input opcode_e op,
	input logic signed [data_width - 1:0] a,
	input logic signed [data_width - 1:0] b,
	input logic saturate,
	input logic [shift_width - 1:0] shift,
	output logic ack,
	output logic signed [data_width - 1:0] result
);
	localparam int acc_width = 2 * data_width;
	localparam logic signed [acc_width - 1:0] sat_max =
		{{(data_width + 1){1'b0}}, {(data_width - 1){1'b1}}};
	localparam logic signed [acc_width - 1:0] sat_min =
		{{(data_width + 1){1'b1}}, {(data_width - 1){1'b0}}};

	logic signed [acc_width - 1:0] product;
	logic signed [acc_width - 1:0] scaled;
	logic signed [acc_width - 1:0] accumulator;
	logic product_valid;
	logic scaled_valid;
	logic start;
	logic acc_read;

	function automatic logic signed [data_width - 1:0] clip(
		input logic signed [acc_width - 1:0] value
	);
		if (value > sat_max)
			return sat_max[data_width - 1:0];
		else if (value < sat_min)
			return sat_min[data_width - 1:0];
		else
			return value[data_width - 1:0];
	endfunction

	// A new request is taken only once the previous one has fully drained
	assign start = req && !ack && !product_valid && !scaled_valid;
	assign acc_read = start && op == MOV_ACC;

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
			product_valid <= 1'b0;
			scaled_valid <= 1'b0;
			accumulator <= '0;
		end else begin
			product_valid <= start && op != MOV_ACC;
			scaled_valid <= product_valid;

			if (acc_read) begin
				ack <= 1'b1;  // Reading the accumulator skips the multiplier
			end else if (scaled_valid) begin
				ack <= 1'b1;
				if (op == MACZ)
					accumulator <= scaled;
				else if (op == MAC)
					accumulator <= accumulator + scaled;
			end else if (!req) begin
				ack <= 1'b0;
			end
		end
	end

	// Product, then shift to the Q format picked by the instruction, then narrow
	always_ff @(posedge clk) begin
		product <= a * b;
		scaled <= product >>> (data_width - 1 - shift);

		if (acc_read)
			result <= clip(accumulator);
		else if (scaled_valid)
			result <= saturate ? clip(scaled) : scaled[data_width - 1:0];
	end

endmodule

// File: source/block_sequencer.sv
module block_sequencer import dsp_pkg::*; #(
	parameter int data_width = 16,
	parameter int n_blocks = 16
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic signed [data_width - 1:0] sample_in,
	input instr_t instr,
	input logic signed [data_width - 1:0] operand_a,
	input logic signed [data_width - 1:0] operand_b,
	input logic [$clog2(n_blocks) - 1:0] last_block,
	input logic signed [data_width - 1:0] channel0,
	input logic alu_ack,
	input logic signed [data_width - 1:0] alu_result,
	input logic mac_ack,
	input logic signed [data_width - 1:0] mac_result,
	output logic ready,
	output logic signed [data_width - 1:0] sample_out,
	output logic [$clog2(n_blocks) - 1:0] block_index,
	output logic operand_fetch,
	output logic ch_write,
	output logic [reg_addr_width - 1:0] ch_addr,
	output logic signed [data_width - 1:0] ch_value,
	output logic sample_load,
	output logic signed [data_width - 1:0] sample_value,
	output logic alu_req,
	output logic mac_req,
	output opcode_e unit_op,
	output logic signed [data_width - 1:0] unit_a,
	output logic signed [data_width - 1:0] unit_b,
	output logic unit_saturate,
	output logic [shift_width - 1:0] unit_shift
);
	seq_state_e state;
	logic signed [data_width - 1:0] result;
	logic use_mac;
	logic writes_dest;
	logic unit_ack;

	assign use_mac = instr.op inside {MUL, MACZ, MAC, MOV_ACC};
	// MACZ and MAC only touch the accumulator
	assign writes_dest = !(instr.op inside {NOP, MACZ, MAC});
	assign unit_ack = use_mac ? mac_ack : alu_ack;

	// Instruction and operands stay registered in the memory for the whole block
	assign unit_op = instr.op;
	assign unit_a = operand_a;
	assign unit_b = operand_b;
	assign unit_saturate = instr.saturate;
	assign unit_shift = instr.shift;

	assign sample_load = (state == IDLE) && tick;
	assign sample_value = sample_in;
	assign operand_fetch = (state == FETCH_OPERANDS);

	assign ch_write = (state == WRITE_BACK) && writes_dest;
	assign ch_addr = instr.dest;
	assign ch_value = result;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			ready <= 1'b1;
			sample_out <= '0;
			block_index <= '0;
			alu_req <= 1'b0;
			mac_req <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (tick) begin
						ready <= 1'b0;
						block_index <= '0;
						state <= FETCH_INSTR;
					end
				end

				FETCH_INSTR:
					state <= FETCH_OPERANDS;

				FETCH_OPERANDS:
					state <= DISPATCH;

				DISPATCH: begin
					if (instr.op == NOP) begin
						state <= NEXT_BLOCK;
					end else if (!unit_ack) begin
						// The unit must have finished its last four-phase cycle
						alu_req <= !use_mac;
						mac_req <= use_mac;
						state <= WAIT_UNIT;
					end
				end

				WAIT_UNIT: begin
					if (unit_ack) begin
						result <= use_mac ? mac_result : alu_result;
						alu_req <= 1'b0;
						mac_req <= 1'b0;
						state <= WRITE_BACK;
					end
				end

				WRITE_BACK:
					state <= NEXT_BLOCK;

				NEXT_BLOCK: begin
					if (block_index == last_block) begin
						state <= FINISH;
					end else begin
						block_index <= block_index + 1'b1;
						state <= FETCH_INSTR;
					end
				end

				FINISH: begin
					sample_out <= channel0;
					ready <= 1'b1;
					state <= IDLE;
				end

				default:
					state <= IDLE;
			endcase
		end
	end

endmodule

// File: source/dsp_core.sv
module dsp_core import dsp_pkg::*; #(
	parameter int data_width = 16,
	parameter int n_blocks = 16
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic signed [data_width - 1:0] sample_in,
	output logic signed [data_width - 1:0] sample_out,
	output logic ready,
	input logic instr_write,
	input logic [$clog2(n_blocks) - 1:0] instr_block,
	input instr_t instr_value,
	input logic reg_write,
	input logic [$clog2(n_blocks) - 1:0] reg_block,
	input logic [reg_addr_width - 1:0] reg_index,
	input logic signed [data_width - 1:0] reg_value
);
	instr_t instr;
	logic signed [data_width - 1:0] operand_a;
	logic signed [data_width - 1:0] operand_b;
	logic [$clog2(n_blocks) - 1:0] last_block;
	logic signed [data_width - 1:0] channel0;
	logic [$clog2(n_blocks) - 1:0] block_index;
	logic operand_fetch;
	logic ch_write;
	logic [reg_addr_width - 1:0] ch_addr;
	logic signed [data_width - 1:0] ch_value;
	logic sample_load;
	logic signed [data_width - 1:0] sample_value;
	logic alu_req;
	logic alu_ack;
	logic signed [data_width - 1:0] alu_result;
	logic mac_req;
	logic mac_ack;
	logic signed [data_width - 1:0] mac_result;
	opcode_e unit_op;
	logic signed [data_width - 1:0] unit_a;
	logic signed [data_width - 1:0] unit_b;
	logic unit_saturate;
	logic [shift_width - 1:0] unit_shift;

	block_memory #(.data_width(data_width), .n_blocks(n_blocks)) u_memory (.*);

	block_sequencer #(.data_width(data_width), .n_blocks(n_blocks)) u_sequencer (.*);

	// Both units see the same operands and only the request picks one
	alu_unit #(.data_width(data_width)) u_alu (
		.clk(clk),
		.reset(reset),
		.req(alu_req),
		.op(unit_op),
		.a(unit_a),
		.b(unit_b),
		.saturate(unit_saturate),
		.shift(unit_shift),
		.ack(alu_ack),
		.result(alu_result)
	);

	mac_unit #(.data_width(data_width)) u_mac (
		.clk(clk),
		.reset(reset),
		.req(mac_req),
		.op(unit_op),
		.a(unit_a),
		.b(unit_b),
		.saturate(unit_saturate),
		.shift(unit_shift),
		.ack(mac_ack),
		.result(mac_result)
	);

endmodule

// File: test/dsp_model.svh
`ifndef DSP_MODEL_SVH
`define DSP_MODEL_SVH

// These mirror the core state and are kept in step by the host write tasks and run_program
instr_t prog_mirror [n_blocks];
int bank_mirror [n_blocks][n_registers];
int chan_mirror [n_channels];
int acc_mirror;
int last_mirror;

function automatic void clear_model();
	foreach (chan_mirror[c])
		chan_mirror[c] = 0;
	acc_mirror = 0;
	last_mirror = 0;
endfunction

function automatic int wrap_value(longint v);
	logic signed [data_width - 1:0] low;
	low = v[data_width - 1:0];
	return int'(low);
endfunction

function automatic int clip_value(longint v);
	if (v > max_value)
		return max_value;
	else if (v < min_value)
		return min_value;
	else
		return int'(v);
endfunction

// Runs one tick by loading the sample and every block in order, then returns channel 0
function automatic int run_program(int sample);
	instr_t i;
	int a;
	int b;
	int res;
	int hi;
	int lo;
	longint scaled;
	chan_mirror[0] = wrap_value(sample);
	for (int blk = 0; blk <= last_mirror; blk++) begin
		i = prog_mirror[blk];
		a = i.src_a_reg ? bank_mirror[blk][i.src_a] : chan_mirror[i.src_a];
		b = i.src_b_reg ? bank_mirror[blk][i.src_b] : chan_mirror[i.src_b];
		scaled = (longint'(a) * b) >>> (data_width - 1 - int'(i.shift));
		hi = max_value >>> i.shift;
		lo = min_value >>> i.shift;
		res = 0;
		case (i.op)
			ADD: res = i.saturate ? clip_value(a + b) : wrap_value(a + b);
			SUB: res = i.saturate ? clip_value(a - b) : wrap_value(a - b);
			LSH: res = wrap_value(a <<< 1);
			RSH: res = (a & ((1 << data_width) - 1)) >> 1;  // Logical shift within data_width bits
			ARSH: res = a >>> 1;
			ABS: res = wrap_value(a < 0 ? -a : a);
			MOV: res = a;
			CLAMP: res = (a > hi) ? hi : (a < lo) ? lo : a;
			MUL: res = i.saturate ? clip_value(scaled) : wrap_value(scaled);
			MACZ: acc_mirror = int'(scaled);
			MAC: acc_mirror = acc_mirror + int'(scaled);
			MOV_ACC: res = clip_value(acc_mirror);
			default: res = 0;
		endcase
		if (!(i.op inside {NOP, MACZ, MAC}))
			chan_mirror[i.dest] = res;
	end
	return chan_mirror[0];
endfunction

`endif

// File: test/dsp_core_tb.sv
module dsp_core_tb import dsp_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int data_width = 16;
	localparam int n_blocks = 16;
	localparam int block_bits = $clog2(n_blocks);
	localparam int max_value = 2 ** (data_width - 1) - 1;
	localparam int min_value = -(2 ** (data_width - 1));
	localparam int total_ticks = 5 + 50 + 20 + 10 + 2;
	// Per tick budget plus two full register loads and the program writes
	localparam int timeout_limit = total_ticks * (n_blocks * 12 + 10)
		+ 2 * n_blocks * n_registers + 10 * n_blocks + 100;

	logic clk;
	logic reset;
	logic tick;
	logic signed [data_width - 1:0] sample_in;
	logic signed [data_width - 1:0] sample_out;
	logic ready;
	logic instr_write;
	logic [block_bits - 1:0] instr_block;
	instr_t instr_value;
	logic reg_write;
	logic [block_bits - 1:0] reg_block;
	logic [reg_addr_width - 1:0] reg_index;
	logic signed [data_width - 1:0] reg_value;
	int cycle_count = 0;
	int test_errors;
	int tests_passed;
	int tests_failed;

	`include "dsp_model.svh"

	dsp_core #(.data_width(data_width), .n_blocks(n_blocks)) dut0 (.*);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Timed out after %0d cycles waiting for ready", cycle_count);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic check_sample(string name, logic signed [data_width - 1:0] expected,
		logic signed [data_width - 1:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %0d actual %0d", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic check_ready(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %b actual %b", name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic report_test(string name);
		if (test_errors == 0) begin
			$display("test %s passed", name);
			tests_passed++;
		end else begin
			$display("test %s failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	task automatic write_instr(int blk, instr_t value);
		instr_write = 1'b1;
		instr_block = blk[block_bits - 1:0];
		instr_value = value;
		@(posedge clk);
		#1;
		instr_write = 1'b0;
		prog_mirror[blk] = value;
		if (blk > last_mirror)
			last_mirror = blk;
	endtask

	task automatic write_reg(int blk, int idx, logic signed [data_width - 1:0] value);
		reg_write = 1'b1;
		reg_block = blk[block_bits - 1:0];
		reg_index = idx[reg_addr_width - 1:0];
		reg_value = value;
		@(posedge clk);
		#1;
		reg_write = 1'b0;
		bank_mirror[blk][idx] = int'(value);
	endtask

	task automatic wait_ready();
		while (ready !== 1'b1) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_tick(string name, logic signed [data_width - 1:0] sample);
		int expected;
		expected = run_program(int'(sample));
		tick = 1'b1;
		sample_in = sample;
		@(posedge clk);
		#1;
		tick = 1'b0;
		check_ready(name, 1'b0, ready);
		wait_ready();
		check_sample(name, expected[data_width - 1:0], sample_out);
	endtask

	function automatic instr_t random_instr(opcode_e op, bit saturate);
		instr_t i;
		i.op = op;
		i.saturate = saturate;
		{i.shift, i.src_a, i.src_b, i.dest} = 16'($urandom);
		{i.src_a_reg, i.src_b_reg} = 2'($urandom);
		return i;
	endfunction

	function automatic logic signed [data_width - 1:0] random_sample();
		return data_width'($urandom);
	endfunction

	function automatic logic signed [data_width - 1:0] near_limit();
		int offset;
		offset = $urandom_range(0, 255);
		if ($urandom_range(0, 1) == 1)
			return data_width'(max_value - offset);
		else
			return data_width'(min_value + offset);
	endfunction

	initial begin
		instr_t nop_instr;
		instr_t i;
		logic signed [data_width - 1:0] reg_val;
		logic signed [data_width - 1:0] s;
		logic stayed_ready;
		void'($urandom(26));
		clk = 1'b0;
		reset = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		instr_write = 1'b0;
		instr_block = '0;
		instr_value = '0;
		reg_write = 1'b0;
		reg_block = '0;
		reg_index = '0;
		reg_value = '0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		nop_instr = '0;
		clear_model();
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;

		check_ready("reset_ready", 1'b1, ready);
		check_sample("reset_sample", '0, sample_out);
		report_test("reset_state");

		write_instr(0, nop_instr);
		for (int t = 0; t < 5; t++)
			run_tick("nop_passthrough", random_sample());
		report_test("nop_passthrough");

		for (int blk = 0; blk < n_blocks; blk++)
			for (int r = 0; r < n_registers; r++)
				write_reg(blk, r, random_sample());
		for (int p = 0; p < 5; p++) begin
			for (int blk = 0; blk < n_blocks; blk++) begin
				i = random_instr(opcode_e'($urandom_range(ADD, CLAMP)), 1'($urandom));
				if (blk == n_blocks - 1)
					i.dest = '0;  // Last block always feeds the output
				write_instr(blk, i);
			end
			for (int t = 0; t < 10; t++)
				run_tick("alu_random", random_sample());
		end
		report_test("alu_random");

		for (int blk = 0; blk < n_blocks; blk++)
			for (int r = 0; r < n_registers; r++)
				write_reg(blk, r, near_limit());
		for (int p = 0; p < 2; p++) begin
			for (int blk = 0; blk < n_blocks; blk++) begin
				i = random_instr(MUL, p == 0);
				if (blk == n_blocks - 1)
					i.dest = '0;
				write_instr(blk, i);
			end
			for (int t = 0; t < 10; t++)
				run_tick(p == 0 ? "mul_saturate" : "mul_truncate", near_limit());
		end
		report_test("mul");

		write_instr(0, random_instr(MACZ, 1'b0));
		write_instr(1, random_instr(MAC, 1'b0));
		write_instr(2, random_instr(MAC, 1'b0));
		i = random_instr(MOV_ACC, 1'b1);
		i.dest = '0;
		write_instr(3, i);
		for (int blk = 4; blk < n_blocks; blk++)
			write_instr(blk, nop_instr);
		for (int t = 0; t < 10; t++)
			run_tick("mac_chain", near_limit());
		report_test("mac_chain");

		// Block 0 adds bank register 5 to channel 0 and every later block is a NOP
		reg_val = data_width'($urandom_range(1000, 2000));
		write_reg(0, 5, reg_val);
		i = nop_instr;
		i.op = ADD;
		i.saturate = 1'b1;
		i.src_b = 4'd5;
		i.src_b_reg = 1'b1;
		write_instr(0, i);
		for (int blk = 1; blk < n_blocks; blk++)
			write_instr(blk, nop_instr);
		s = data_width'($urandom_range(0, 1000));
		tick = 1'b1;
		sample_in = s;
		@(posedge clk);
		#1;
		// The core is busy here and has not yet read channel 0
		sample_in = data_width'($urandom_range(3000, 4000));
		@(posedge clk);
		#1;
		tick = 1'b0;
		check_ready("busy_tick", 1'b0, ready);
		wait_ready();
		check_sample("host_register", s + reg_val, sample_out);
		stayed_ready = 1'b1;
		repeat (n_blocks * 12 + 10) begin
			@(posedge clk);
			#1;
			if (ready !== 1'b1)
				stayed_ready = 1'b0;
		end
		check_ready("busy_tick_ignored", 1'b1, stayed_ready);
		check_sample("busy_tick_output", s + reg_val, sample_out);
		report_test("host_register");

		$display("tests passed %0d failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+test
source/dsp_pkg.sv
source/block_memory.sv
source/alu_unit.sv
source/mac_unit.sv
source/block_sequencer.sv
source/dsp_core.sv
test/dsp_core_tb.sv

// File: Makefile
TOP = dsp_core_tb

all: run

run:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^=== PASS ===$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -Wall -Wno-fatal --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
